/* lv_fault_top.f */
source/lv_cfg_pkg.sv
source/lv_fault_pkg.sv
source/gnrl_sync.sv
source/lv_analog_int_proc.sv
source/lv_uvlo_filter.sv
source/lv_fault_report.sv
source/lv_fault_top.sv
verification/tb_lv_fault_top.sv

/* verification/tb_lv_fault_top.sv */
/*
 * testbench for the low-voltage fault top level
 *   - host req/ack model, reference functions, status checker
 *   - reset, dead-time, mismatch, uvlo and back-pressure tests
 */
`timescale 1ns/10ps
`default_nettype none

module tb_lv_fault_top
    import lv_cfg_pkg::*;
    import lv_fault_pkg::*;
();

    localparam int CLK_MHZ     = 25;
    localparam int UVLO_CYC    = 8;
    localparam int REQ_TIMEOUT = 40;
    localparam int MAX_N       = GATE_BACK_NS_MAX * CLK_MHZ / 1000 + 1;
    // reset, dead-time, 8 mismatch rounds, uvlo, back-pressure, margin
    localparam int WD_CYC      = 20 + 150 + 8 * (3 * MAX_N + 120) + 150 + 300 + 500;

    logic          clk;
    logic          rst_n;
    logic          lv_pwm_dt;
    logic          lv_gate_vs_pwm;
    logic          lv_uvlo;
    logic          int_ack;
    logic          int_req;
    logic          pwm_block;
    vge_dly_code_t vge_mon_dly;
    lv_fault_t     fault_status;
    lv_fault_t     cmp_got;
    lv_fault_t     cmp_exp;
    lv_fault_t     got_q [$];
    lv_fault_t     exp_q [$];
    logic [31:0]   rng_state     = 32'h2cad_35c2;
    int            error_cnt     = 0;
    int            check_cnt     = 0;
    int            test_cnt      = 0;
    int            pass_cnt      = 0;
    int            test_err_base = 0;

    lv_fault_top #(
        .P_CLK_MHZ       (CLK_MHZ),
        .P_UVLO_FILT_CYC (UVLO_CYC)
    ) i_dut (
        .i_clk            (clk),
        .i_rst_n          (rst_n),
        .i_lv_pwm_dt      (lv_pwm_dt),
        .i_lv_gate_vs_pwm (lv_gate_vs_pwm),
        .i_lv_uvlo        (lv_uvlo),
        .i_vge_mon_dly    (vge_mon_dly),
        .i_int_ack        (int_ack),
        .o_int_req        (int_req),
        .o_fault_status   (fault_status),
        .o_pwm_block      (pwm_block)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // ==============================
    // reference model
    // ==============================
    function automatic logic [31:0] next_rand();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    // filter length in cycles as ns * MHz / 1000 rounded up
    function automatic int lv_gate_back_cycles(input vge_dly_code_t code);
        int prod;
        int n;
        prod = GATE_BACK_NS[code] * CLK_MHZ;
        n    = prod / 1000;
        if (n * 1000 < prod) begin
            n = n + 1;
        end
        return n;
    endfunction

    function automatic lv_fault_t expected_status(input logic dt, input logic mm,
                                                  input logic uvlo);
        lv_fault_t s;
        s.dt_err   = dt;
        s.mm_err   = mm;
        s.uvlo_err = uvlo;
        return s;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        check_cnt++;
        if (got !== exp) begin
            error_cnt++;
            $display("[ERROR] %0d ns: %s is %0h, expected %0h", $time, name, got, exp);
        end
    endtask

    task automatic check_outputs_idle();
        check_value("o_int_req", int_req, 1'b0);
        check_value("o_pwm_block", pwm_block, 1'b0);
        check_value("o_fault_status", fault_status, expected_status(1'b0, 1'b0, 1'b0));
    endtask

    // compares captured host status with the reference one pair at a time
    always @(negedge clk) begin
        if (got_q.size() > 0 && exp_q.size() > 0) begin
            cmp_got = got_q.pop_front();
            cmp_exp = exp_q.pop_front();
            check_value("o_fault_status", cmp_got, cmp_exp);
        end
    end

    // ==============================
    // stimulus and host model
    // ==============================
    task automatic drive_pulse(input int src, input int len);
        case (src)
            0:       lv_pwm_dt      = 1'b1;
            1:       lv_gate_vs_pwm = 1'b1;
            default: lv_uvlo        = 1'b1;
        endcase
        repeat (len) @(negedge clk);
        lv_pwm_dt      = 1'b0;
        lv_gate_vs_pwm = 1'b0;
        lv_uvlo        = 1'b0;
    endtask

    task automatic expect_no_req(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            check_value("o_int_req", int_req, 1'b0);
        end
    endtask

    task automatic wait_for_req(output bit seen);
        int n;
        n = 0;
        while (!int_req && n < REQ_TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        seen = int_req;
        if (!seen) begin
            error_cnt++;
            $display("%0d ns: no interrupt request within %0d cycles", $time, REQ_TIMEOUT);
        end
    endtask

    // ack after a random delay and release once req has dropped
    task automatic host_handshake(input lv_fault_t exp, output lv_fault_t status);
        bit seen;
        int n;
        int dly;
        status = '0;
        wait_for_req(seen);
        if (seen) begin
            dly = 1 + int'(next_rand() >> 30);
            repeat (dly) @(negedge clk);
            status = fault_status;
            exp_q.push_back(exp);
            got_q.push_back(status);
            check_value("o_pwm_block", pwm_block, 1'b1);
            int_ack = 1'b1;
            n = 0;
            while (int_req && n < REQ_TIMEOUT) begin
                @(negedge clk);
                n++;
            end
            if (int_req) begin
                error_cnt++;
                $display("%0d ns: request still high %0d cycles after ack", $time, n);
            end
            int_ack = 1'b0;
            repeat (2) @(negedge clk);
        end
    endtask

    task automatic finish_test(input string name);
        test_cnt++;
        if (error_cnt == test_err_base) begin
            pass_cnt++;
            $display("test %s: passed", name);
        end else begin
            $display("test %s: failed with %0d errors", name, error_cnt - test_err_base);
        end
        test_err_base = error_cnt;
    endtask

    // ==============================
    // test sequence
    // ==============================
    initial begin
        lv_fault_t st;
        int        n;
        bit        seen;
        rst_n          = 1'b0;
        lv_pwm_dt      = 1'b0;
        lv_gate_vs_pwm = 1'b0;
        lv_uvlo        = 1'b0;
        vge_mon_dly    = '0;
        int_ack        = 1'b0;

        // outputs quiet during and after reset
        repeat (8) begin
            @(negedge clk);
            check_outputs_idle();
        end
        rst_n = 1'b1;
        repeat (6) begin
            @(negedge clk);
            check_outputs_idle();
        end
        finish_test("reset");

        // one report per rising edge while a held flag stays silent
        lv_pwm_dt = 1'b1;
        host_handshake(expected_status(1'b1, 1'b0, 1'b0), st);
        check_value("o_pwm_block", pwm_block, 1'b0);
        expect_no_req(20);
        lv_pwm_dt = 1'b0;
        expect_no_req(6);
        finish_test("dead_time");

        repeat (8) begin
            vge_mon_dly = vge_dly_code_t'(next_rand() >> 28);
            n = lv_gate_back_cycles(vge_mon_dly);
            drive_pulse(1, n - 1);
            expect_no_req(n + 10);
            repeat (2 + int'(next_rand() >> 30)) @(negedge clk);
            drive_pulse(1, n + 2);
            repeat (4) @(negedge clk);
            host_handshake(expected_status(1'b0, 1'b1, 1'b0), st);
            expect_no_req(6);
        end
        finish_test("mismatch");

        drive_pulse(2, UVLO_CYC - 2);
        expect_no_req(UVLO_CYC + 10);
        drive_pulse(2, UVLO_CYC + 4);
        repeat (4) @(negedge clk);
        host_handshake(expected_status(1'b0, 1'b0, 1'b1), st);
        expect_no_req(6);
        finish_test("uvlo");

        // mismatch arrives while the dead-time report waits for ack
        drive_pulse(0, 4);
        wait_for_req(seen);
        vge_mon_dly = '0;
        n = lv_gate_back_cycles(vge_mon_dly);
        drive_pulse(1, n + 5);
        repeat (4) @(negedge clk);
        check_value("o_int_req", int_req, 1'b1);
        check_value("o_fault_status", fault_status, expected_status(1'b1, 1'b0, 1'b0));
        host_handshake(expected_status(1'b1, 1'b0, 1'b0), st);
        host_handshake(expected_status(1'b0, 1'b1, 1'b0), st);
        check_value("o_pwm_block", pwm_block, 1'b0);
        expect_no_req(6);
        finish_test("back_pressure");

        $display("tests %0d, passed %0d, failed %0d, checks %0d, errors %0d",
                 test_cnt, pass_cnt, test_cnt - pass_cnt, check_cnt, error_cnt);
        if (error_cnt == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    initial begin
        repeat (WD_CYC) @(posedge clk);
        $display("watchdog expired after %0d cycles, tests did not complete", WD_CYC);
        $display("Finished with errors");
        $finish;
    end

endmodule : tb_lv_fault_top

`default_nettype wire

/* source/lv_fault_top.sv */
/*
 * low-voltage fault interrupt top level
 * comparator qualification, uvlo debounce and host reporter
 */
`timescale 1ns/10ps
`default_nettype none

module lv_fault_top
    import lv_cfg_pkg::*;
    import lv_fault_pkg::*;
#(
    parameter int P_CLK_MHZ       = CLK_MHZ_DEFAULT,
    parameter int P_UVLO_FILT_CYC = 8
) (
    input  wire logic          i_clk,
    input  wire logic          i_rst_n,
    input  wire logic          i_lv_pwm_dt,
    input  wire logic          i_lv_gate_vs_pwm,
    input  wire logic          i_lv_uvlo,
    input  wire vge_dly_code_t i_vge_mon_dly,
    input  wire logic          i_int_ack,
    output logic               o_int_req,
    output lv_fault_t          o_fault_status,
    output logic               o_pwm_block
);

    logic      dt_err;
    logic      mm_err;
    logic      uvlo_err;
    lv_fault_t fault_evt;

    lv_analog_int_proc #(
        .P_CLK_MHZ (P_CLK_MHZ)
    ) u_analog_int_proc (
        .i_clk            (i_clk),
        .i_rst_n          (i_rst_n),
        .i_lv_pwm_dt      (i_lv_pwm_dt),
        .i_lv_gate_vs_pwm (i_lv_gate_vs_pwm),
        .i_vge_mon_dly    (i_vge_mon_dly),
        .o_lv_pwm_dterr   (dt_err),
        .o_lv_pwm_mmerr   (mm_err)
    );

    lv_uvlo_filter #(
        .P_UVLO_FILT_CYC (P_UVLO_FILT_CYC)
    ) u_uvlo_filter (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_lv_uvlo  (i_lv_uvlo),
        .o_uvlo_err (uvlo_err)
    );

    // qualified events toward the reporter
    assign fault_evt = '{dt_err: dt_err, mm_err: mm_err, uvlo_err: uvlo_err};

    lv_fault_report u_fault_report (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_fault_evt    (fault_evt),
        .i_int_ack      (i_int_ack),
        .o_int_req      (o_int_req),
        .o_fault_status (o_fault_status),
        .o_pwm_block    (o_pwm_block)
    );

endmodule : lv_fault_top

`default_nettype wire

/* source/lv_fault_report.sv */
/*
 * fault latching and host reporting
 *   - sticky pending fault set
 *   - pwm blocking while anything is pending or reported
 *   - four-phase req/ack FSM with status snapshot
 */
`timescale 1ns/10ps
`default_nettype none

module lv_fault_report
    import lv_fault_pkg::*;
(
    input  wire logic      i_clk,
    input  wire logic      i_rst_n,
    input  wire lv_fault_t i_fault_evt,
    input  wire logic      i_int_ack,
    output logic           o_int_req,
    output lv_fault_t      o_fault_status,
    output logic           o_pwm_block
);

    rpt_state_t state;
    lv_fault_t  pending;
    lv_fault_t  clr_mask;
    lv_fault_t  inflight;
    logic       ack_take;

    // ack seen while the request is up
    assign ack_take = (state == RPT_REQ) && i_int_ack;

    // bits handed to the host, cleared on ack
    assign clr_mask = ack_take ? o_fault_status : lv_fault_t'('0);

    // reported but handshake not finished yet
    assign inflight = (state != RPT_IDLE) ? o_fault_status : lv_fault_t'('0);

    // ==============================
    // pending set
    // ==============================
    // new events win over the clear, so active sources re-latch
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            pending <= '0;
        end else begin
            pending <= lv_fault_t'((pending & ~clr_mask) | i_fault_evt);
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_pwm_block <= 1'b0;
        end else begin
            o_pwm_block <= |(pending | inflight);
        end
    end

    // ==============================
    // host handshake FSM
    // ==============================
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state          <= RPT_IDLE;
            o_int_req      <= 1'b0;
            o_fault_status <= '0;
        end else begin
            case (state)
                RPT_IDLE: begin
                    // status tracks pending until a request goes out
                    o_fault_status <= pending;
                    if (|pending) begin
                        o_int_req <= 1'b1;
                        state     <= RPT_REQ;
                    end
                end
                RPT_REQ: begin
                    // status frozen while req is high
                    if (ack_take) begin
                        o_int_req <= 1'b0;
                        state     <= RPT_WAIT_ACK_LOW;
                    end
                end
                RPT_WAIT_ACK_LOW: begin
                    if (!i_int_ack) begin
                        state <= RPT_IDLE;
                    end
                end
                default: begin
                    o_int_req <= 1'b0;
                    state     <= RPT_IDLE;
                end
            endcase
        end
    end

endmodule : lv_fault_report

`default_nettype wire

/* source/lv_uvlo_filter.sv */
/*
 * undervoltage flag synchronizer and debounce
 */
`timescale 1ns/10ps
`default_nettype none

module lv_uvlo_filter #(
    parameter int P_UVLO_FILT_CYC = 8
) (
    input  wire logic i_clk,
    input  wire logic i_rst_n,
    input  wire logic i_lv_uvlo,
    output logic      o_uvlo_err
);

    localparam int CNT_W = $clog2(P_UVLO_FILT_CYC + 1);

    logic             uvlo_sync;
    logic [CNT_W-1:0] uvlo_cnt;

    gnrl_sync #(
        .DW      (1),
        .DEF_VAL (1'b0)
    ) u_uvlo_sync (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_data  (i_lv_uvlo),
        .o_data  (uvlo_sync)
    );

    // ==============================
    // debounce counter
    // ==============================
    // any low cycle restarts the count
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            uvlo_cnt <= '0;
        end else if (!uvlo_sync) begin
            uvlo_cnt <= '0;
        end else if (uvlo_cnt != CNT_W'(P_UVLO_FILT_CYC)) begin
            uvlo_cnt <= uvlo_cnt + 1'b1;
        end
    end

    // saturated and still low-voltage
    assign o_uvlo_err = uvlo_sync & (uvlo_cnt == CNT_W'(P_UVLO_FILT_CYC));

endmodule : lv_uvlo_filter

`default_nettype wire

/* source/lv_analog_int_proc.sv */
/*
 * low-voltage comparator flag qualification
 *   - dead-time flag to a rising-edge strobe
 *   - gate vs pwm mismatch with programmable filter time
 */
`timescale 1ns/10ps
`default_nettype none

module lv_analog_int_proc
    import lv_cfg_pkg::*;
#(
    parameter int P_CLK_MHZ = CLK_MHZ_DEFAULT
) (
    input  wire logic          i_clk,
    input  wire logic          i_rst_n,
    input  wire logic          i_lv_pwm_dt,
    input  wire logic          i_lv_gate_vs_pwm,
    input  wire vge_dly_code_t i_vge_mon_dly,
    output logic               o_lv_pwm_dterr,
    output logic               o_lv_pwm_mmerr
);

    // longest filter in cycles, rounded up
    localparam int MM_CYC_MAX = (GATE_BACK_NS_MAX * P_CLK_MHZ + 999) / 1000;
    localparam int CNT_W      = $clog2(MM_CYC_MAX + 1);

    logic             dt_sync;
    logic             dt_sync_q;
    logic             mm_sync;
    logic [CNT_W-1:0] mm_cnt;
    logic [CNT_W-1:0] mm_lim;
    logic [CNT_W-1:0] lim_tbl [16];

    // ==============================
    // input synchronizers
    // ==============================
    gnrl_sync #(
        .DW      (1),
        .DEF_VAL (1'b0)
    ) u_dt_sync (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_data  (i_lv_pwm_dt),
        .o_data  (dt_sync)
    );

    gnrl_sync #(
        .DW      (1),
        .DEF_VAL (1'b0)
    ) u_mm_sync (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_data  (i_lv_gate_vs_pwm),
        .o_data  (mm_sync)
    );

    // ==============================
    // dead-time edge
    // ==============================
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            dt_sync_q <= 1'b0;
        end else begin
            dt_sync_q <= dt_sync;
        end
    end

    assign o_lv_pwm_dterr = dt_sync & ~dt_sync_q;

    // ==============================
    // mismatch filter
    // ==============================
    // terminal count per code is N-1, N = ceil(ns * MHz / 1000)
    for (genvar g = 0; g < 16; g++) begin : g_lim
        assign lim_tbl[g] = CNT_W'((GATE_BACK_NS[g] * P_CLK_MHZ + 999) / 1000 - 1);
    end

    assign mm_lim = lim_tbl[i_vge_mon_dly];

    // counts consecutive mismatch cycles, holds at the limit
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            mm_cnt <= '0;
        end else if (!mm_sync) begin
            mm_cnt <= '0;
        end else if (mm_cnt < mm_lim) begin
            mm_cnt <= mm_cnt + 1'b1;
        end
    end

    // high from the N-th cycle until the flag drops
    assign o_lv_pwm_mmerr = mm_sync & (mm_cnt >= mm_lim);

endmodule : lv_analog_int_proc

`default_nettype wire

/* source/gnrl_sync.sv */
/*
 * two-flop synchronizer for asynchronous inputs
 * width and reset value are parameters
 */
`timescale 1ns/10ps
`default_nettype none

module gnrl_sync #(
    parameter int            DW      = 1,
    parameter logic [DW-1:0] DEF_VAL = '0
) (
    input  wire logic          i_clk,
    input  wire logic          i_rst_n,
    input  wire logic [DW-1:0] i_data,
    output logic      [DW-1:0] o_data
);

    // first stage may go metastable
    logic [DW-1:0] meta_q;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            meta_q <= DEF_VAL;
            o_data <= DEF_VAL;
        end else begin
            meta_q <= i_data;
            o_data <= meta_q;
        end
    end

endmodule : gnrl_sync

`default_nettype wire

/* source/lv_fault_pkg.sv */
/*
 * fault reporting types
 *   - qualified fault bits as one packed struct
 *   - host reporter FSM states
 */
`default_nettype none

package lv_fault_pkg;

    // ==============================
    // fault bits
    // ==============================
    // one bit per qualified source, dt_err is the msb
    typedef struct packed {
        logic dt_err;
        logic mm_err;
        logic uvlo_err;
    } lv_fault_t;

    // ==============================
    // reporter FSM
    // ==============================
    // four-phase req/ack sequence toward the host
    typedef enum logic [1:0] {
        RPT_IDLE         = 2'd0,
        RPT_REQ          = 2'd1,
        RPT_WAIT_ACK_LOW = 2'd2
    } rpt_state_t;

endpackage : lv_fault_pkg

`default_nettype wire

/* source/lv_cfg_pkg.sv */
/*
 * configuration constants for the low-voltage fault block
 *   - default clock frequency
 *   - delay-code type for the mismatch filter
 *   - gate-back filter time table in ns
 */
`default_nettype none

package lv_cfg_pkg;

    // core clock in MHz, overridden from the top level
    localparam int CLK_MHZ_DEFAULT = 25;

    // selects one entry of the gate-back table
    typedef logic [3:0] vge_dly_code_t;

    // ==============================
    // gate-back filter times, ns
    // ==============================
    localparam int GATE_BACK_NS [16] = '{
          100,  200,  400,  600,
          800, 1000, 1200, 1400,
         1600, 1800, 2000, 2400,
         2800, 3200, 3600, 4000
    };

    // longest entry, sizes the filter counter
    localparam int GATE_BACK_NS_MAX = 4000;

endpackage : lv_cfg_pkg

`default_nettype wire
